// ==== project.f ====
verilog/vtage_pkg.sv
verilog/vtage_hash.sv
verilog/vtage_bank.sv
verilog/vtage_provider_select.sv
verilog/vtage_update_unit.sv
verilog/vtage_top.sv
dv/tb_clock_gen.sv
dv/vtage_tb.sv

// ==== dv/vtage_tb.sv ====
// ************************************************************************
// vtage predictor testbench
// table of lookups and feedback, results worked out from the hash rules
// ************************************************************************
module vtage_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import vtage_pkg::*;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 16;

    typedef struct packed {
        logic        lk_en;
        lookup_req_t lk;
        pred_rsp_t   exp;   // expected one cycle after the lookup
        logic        fb_en;
        feedback_t   fb;
    } row_t;

    logic        clk;
    logic        arst_n;
    lookup_req_t fw;
    logic        fw_valid;
    pred_rsp_t   pred;
    logic        pred_valid;
    feedback_t   fb;
    logic        fb_valid;

    row_t  rows[$];
    pc_t   pc_of[4];     // pc and history per test pair
    hist_t hist_of[4];
    bit    idx_used[4][256];
    bit    tag_used[4][64];
    int    seed = 32'h34cf;
    bit    table_ready = 1'b0;

    tb_clock_gen #(.CLK_PERIOD(CLK_PERIOD), .RESET_CYCLES(RESET_CYCLES)) u_clock_gen (
        .clk_o    (clk),
        .arst_n_o (arst_n)
    );

    vtage_top #(.NUM_BANK(4)) UUT (
        .clk_i        (clk),
        .arst_n_i     (arst_n),
        .fw_i         (fw),
        .fw_valid_i   (fw_valid),
        .pred_o       (pred),
        .pred_valid_o (pred_valid),
        .fb_i         (fb),
        .fb_valid_i   (fb_valid)
    );

    task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0d ns: %s got %0h expected %0h", $time, name, got, exp);
            $display("Simulation failed");
            $fatal(1, "stopped at first error");
        end
    endtask

    // bitwise fold, bit i of pc and history lands on index bit i mod 8, tag bit i mod 6
    function automatic logic [13:0] model_hash(input pc_t pc, input hist_t hist, input int b);
        logic [63:0] p;
        logic [63:0] h;
        logic [7:0]  idx;
        logic [5:0]  tag;
        p = 64'(pc);
        h = (b == 3) ? hist : hist & ((64'd1 << (4 ** b)) - 64'd1);
        if (b == 0) begin
            return {p[7:0], 6'd0};
        end
        idx = 8'(b);
        tag = 6'(b);
        for (int i = 0; i < 64; i++) begin
            idx[i % 8] ^= p[i] ^ h[i];
            tag[i % 6] ^= p[i] ^ h[i];
        end
        return {idx, tag};
    endfunction

    // redraw until no bank index or tag is shared with an earlier pair
    task automatic draw_pair(input int p, input int share);
        pc_t         pc;
        hist_t       hist;
        logic [13:0] h;
        bit          clear;
        clear = 1'b0;
        while (!clear) begin
            pc    = (share >= 0) ? pc_of[share] : pc_t'($random(seed));
            hist  = {$random(seed), $random(seed)};
            clear = 1'b1;
            for (int b = 0; b < 4; b++) begin
                h = model_hash(pc, hist, b);
                if ((!(b == 0 && share >= 0) && idx_used[b][h[13:6]]) ||
                    (b > 0 && tag_used[b][h[5:0]])) begin
                    clear = 1'b0;
                end
            end
        end
        for (int b = 0; b < 4; b++) begin
            h = model_hash(pc, hist, b);
            idx_used[b][h[13:6]] = 1'b1;
            tag_used[b][h[5:0]]  = (b > 0);
        end
        pc_of[p]   = pc;
        hist_of[p] = hist;
    endtask

    task automatic lookup_row(input int p, input value_t v, input conf_t c, input bank_t b);
        row_t r;
        r       = '0;
        r.lk_en = 1'b1;
        r.lk    = '{pc: pc_of[p], hist: hist_of[p]};
        r.exp   = '{value: v, conf: c, bank: b};
        rows.push_back(r);
    endtask

    // same_cycle joins the feedback to the previous lookup row
    task automatic feedback_row(input int p, input bank_t b, input value_t act, input bit same_cycle);
        row_t r;
        r = '0;
        if (same_cycle) begin
            r = rows.pop_back();
        end
        r.fb_en = 1'b1;
        r.fb    = '{pc: pc_of[p], hist: hist_of[p], bank: b, actual: act};
        rows.push_back(r);
    endtask

    task automatic build_table();
        draw_pair(0, -1);
        draw_pair(1, 0);   // same pc as pair 0, other history
        draw_pair(2, -1);
        draw_pair(3, -1);
        rows.push_back('0);
        lookup_row(0, 32'h0, 0, 0);   // empty tables miss
        feedback_row(0, 0, 32'h1111_0001, 0);
        lookup_row(0, 32'h1111_0001, 0, 1);
        for (int k = 1; k <= 8; k++) begin
            feedback_row(0, 1, 32'h1111_0001, 0);
            lookup_row(0, 32'h1111_0001, (k > 7) ? 7 : k, 1);   // saturates at 7
        end
        feedback_row(0, 1, 32'h2222_0002, 0);
        lookup_row(0, 32'h2222_0002, 0, 2);
        // other history only hits the shared baseline entry
        lookup_row(1, 32'h1111_0001, 0, 0);
        feedback_row(1, 0, 32'h1111_0001, 0);
        lookup_row(1, 32'h1111_0001, 1, 0);
        lookup_row(0, 32'h2222_0002, 0, 2);
        feedback_row(0, 2, 32'h3333_0003, 0);
        lookup_row(0, 32'h3333_0003, 0, 3);
        feedback_row(0, 3, 32'h3333_0003, 0);
        lookup_row(0, 32'h3333_0003, 1, 3);
        feedback_row(0, 3, 32'h4444_0004, 0);   // top bank, replaced in place
        lookup_row(0, 32'h4444_0004, 0, 3);
        // back to back, a same-edge write is not yet visible
        lookup_row(2, 32'h0, 0, 0);
        feedback_row(2, 0, 32'h5555_0005, 1);
        lookup_row(2, 32'h5555_0005, 0, 1);
        feedback_row(3, 0, 32'h6666_0006, 1);
        lookup_row(3, 32'h6666_0006, 0, 1);
        feedback_row(2, 1, 32'h5555_0005, 1);
        lookup_row(2, 32'h5555_0005, 1, 1);
        feedback_row(3, 1, 32'h7777_0007, 1);
        lookup_row(3, 32'h7777_0007, 0, 2);
        feedback_row(3, 2, 32'h8888_0008, 1);
        lookup_row(3, 32'h8888_0008, 0, 3);
        rows.push_back('0);
    endtask

    task automatic check_outputs(input row_t prev);
        check_value("pred_valid_o", pred_valid, prev.lk_en);
        if (prev.lk_en) begin
            check_value("pred_o.value", pred.value, prev.exp.value);
            check_value("pred_o.conf", pred.conf, prev.exp.conf);
            check_value("pred_o.bank", pred.bank, prev.exp.bank);
        end
    endtask

    initial begin
        row_t prev;
        fw       = '0;
        fw_valid = 1'b0;
        fb       = '0;
        fb_valid = 1'b0;
        prev     = '0;
        build_table();
        table_ready = 1'b1;
        wait (arst_n === 1'b1);
        check_value("pred_o", pred, '0);
        @(posedge clk);
        foreach (rows[i]) begin
            @(negedge clk);
            check_outputs(prev);
            fw       = rows[i].lk;
            fw_valid = rows[i].lk_en;
            fb       = rows[i].fb;
            fb_valid = rows[i].fb_en;
            prev     = rows[i];
        end
        @(negedge clk);
        check_outputs(prev);
        $display("Simulation passed");
        $finish;
    end

    initial begin
        wait (table_ready);
        #((rows.size() * 2 + RESET_CYCLES + 50) * CLK_PERIOD);
        $display("timeout: the run did not finish within its time budget");
        $display("Simulation failed");
        $fatal(1, "watchdog expired");
    end

endmodule

// ==== dv/tb_clock_gen.sv ====
// ************************************************************************
// testbench clock and reset source
// ************************************************************************
module tb_clock_gen #(
    parameter int CLK_PERIOD   = 4,
    parameter int RESET_CYCLES = 16
) (
    output logic clk_o,
    output logic arst_n_o
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk_o    = 1'b0;
        arst_n_o = 1'b0;
        #(RESET_CYCLES * CLK_PERIOD) arst_n_o = 1'b1;   // lands on a falling edge
    end

    always #(CLK_PERIOD / 2) clk_o = ~clk_o;

endmodule

// ==== verilog/vtage_top.sv ====
// ************************************************************************
// vtage value predictor top level
// per-bank hashes and tables, provider selection and feedback update
// ************************************************************************
module vtage_top #(
    parameter int NUM_BANK = 4
) (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    input  vtage_pkg::lookup_req_t fw_i,
    input  logic                   fw_valid_i,
    output vtage_pkg::pred_rsp_t   pred_o,
    output logic                   pred_valid_o,
    input  vtage_pkg::feedback_t   fb_i,
    input  logic                   fb_valid_i
);
    import vtage_pkg::*;

    lookup_req_t              fb_req;     // feedback pc and history for hashing
    index_t [NUM_BANK-1:0]    fw_index;
    tag_t [NUM_BANK-1:0]      fw_tag;
    index_t [NUM_BANK-1:0]    fb_index;
    tag_t [NUM_BANK-1:0]      fb_tag;
    entry_t [NUM_BANK-1:0]    rd_entry;
    logic [NUM_BANK-1:0]      rd_hit;
    entry_t [NUM_BANK-1:0]    fb_entry;
    bank_wr_t [NUM_BANK-1:0]  bank_wr;

    assign fb_req.pc   = fb_i.pc;
    assign fb_req.hist = fb_i.hist;

    for (genvar b = 0; b < NUM_BANK; b++) begin : gen_bank
        vtage_hash u_fw_hash (
            .bank_i  (bank_t'(b)),
            .req_i   (fw_i),
            .index_o (fw_index[b]),
            .tag_o   (fw_tag[b])
        );

        vtage_hash u_fb_hash (
            .bank_i  (bank_t'(b)),
            .req_i   (fb_req),
            .index_o (fb_index[b]),
            .tag_o   (fb_tag[b])
        );

        vtage_bank u_bank (
            .clk_i      (clk_i),
            .arst_n_i   (arst_n_i),
            .rd_index_i (fw_index[b]),
            .rd_tag_i   (fw_tag[b]),
            .rd_entry_o (rd_entry[b]),
            .rd_hit_o   (rd_hit[b]),
            .fb_index_i (fb_index[b]),
            .fb_entry_o (fb_entry[b]),
            .wr_i       (bank_wr[b])
        );
    end

    vtage_provider_select #(
        .NUM_BANK (NUM_BANK)
    ) u_provider_select (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .valid_i  (fw_valid_i),
        .hit_i    (rd_hit),
        .entry_i  (rd_entry),
        .pred_o   (pred_o),
        .valid_o  (pred_valid_o)
    );

    vtage_update_unit #(
        .NUM_BANK (NUM_BANK)
    ) u_update_unit (
        .fb_i       (fb_i),
        .fb_valid_i (fb_valid_i),
        .fb_index_i (fb_index),
        .fb_tag_i   (fb_tag),
        .fb_entry_i (fb_entry),
        .wr_o       (bank_wr)
    );

endmodule

// ==== verilog/vtage_update_unit.sv ====
// ************************************************************************
// feedback update unit
// confidence bump on a correct provider, else replace and allocate up
// ************************************************************************
module vtage_update_unit #(
    parameter int NUM_BANK = 4
) (
    input  vtage_pkg::feedback_t               fb_i,
    input  logic                               fb_valid_i,
    input  vtage_pkg::index_t [NUM_BANK-1:0]   fb_index_i,
    input  vtage_pkg::tag_t [NUM_BANK-1:0]     fb_tag_i,
    input  vtage_pkg::entry_t [NUM_BANK-1:0]   fb_entry_i,
    output vtage_pkg::bank_wr_t [NUM_BANK-1:0] wr_o
);
    import vtage_pkg::*;

    entry_t prov;       // provider entry at its feedback index
    logic   match;
    conf_t  conf_up;

    always_comb begin
        prov = '0;
        for (int b = 0; b < NUM_BANK; b++) begin
            if (bank_t'(b) == fb_i.bank) begin
                prov = fb_entry_i[b];
            end
        end
    end

    // an empty entry never counts as correct
    assign match   = prov.valid && (prov.value == fb_i.actual);
    assign conf_up = (prov.conf == CONF_MAX) ? prov.conf : prov.conf + conf_t'(1);

    always_comb begin
        for (int b = 0; b < NUM_BANK; b++) begin
            wr_o[b].en    = 1'b0;
            wr_o[b].index = fb_index_i[b];
            wr_o[b].entry = '{valid: 1'b1, tag: fb_tag_i[b], value: fb_i.actual, conf: '0};

            if (fb_valid_i && (bank_t'(b) == fb_i.bank)) begin
                wr_o[b].en = 1'b1;   // provider, replaced unless matched
                if (match) begin
                    wr_o[b].entry      = prov;
                    wr_o[b].entry.conf = conf_up;
                end
            end else if (fb_valid_i && !match && (b > 0) &&
                         (bank_t'(b - 1) == fb_i.bank)) begin
                // allocate one bank above the provider
                wr_o[b].en = 1'b1;
            end
        end
    end

endmodule

// ==== verilog/vtage_provider_select.sv ====
// ************************************************************************
// provider selection
// highest hitting bank wins, response registered for one cycle
// ************************************************************************
module vtage_provider_select #(
    parameter int NUM_BANK = 4
) (
    input  logic                               clk_i,
    input  logic                               arst_n_i,
    input  logic                               valid_i,
    input  logic [NUM_BANK-1:0]                hit_i,
    input  vtage_pkg::entry_t [NUM_BANK-1:0]   entry_i,
    output vtage_pkg::pred_rsp_t               pred_o,
    output logic                               valid_o
);
    import vtage_pkg::*;

    pred_rsp_t pred_d;

    // later banks override earlier ones
    always_comb begin
        pred_d = '0;   // no hit gives bank 0, zero value
        for (int b = 0; b < NUM_BANK; b++) begin
            if (hit_i[b]) begin
                pred_d.value = entry_i[b].value;
                pred_d.conf  = entry_i[b].conf;
                pred_d.bank  = bank_t'(b);
            end
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pred_o  <= '0;
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
            if (valid_i) begin
                pred_o <= pred_d;   // hold last result otherwise
            end
        end
    end

endmodule

// ==== verilog/vtage_bank.sv ====
// ************************************************************************
// vtage table bank
// lookup read with tag hit, feedback read, one write port
// ************************************************************************
module vtage_bank (
    input  logic                 clk_i,
    input  logic                 arst_n_i,
    input  vtage_pkg::index_t    rd_index_i,   // lookup side
    input  vtage_pkg::tag_t      rd_tag_i,
    output vtage_pkg::entry_t    rd_entry_o,
    output logic                 rd_hit_o,
    input  vtage_pkg::index_t    fb_index_i,   // feedback side
    output vtage_pkg::entry_t    fb_entry_o,
    input  vtage_pkg::bank_wr_t  wr_i
);
    import vtage_pkg::*;

    localparam int NUM_ENTRY = 2 ** INDEX_WIDTH;

    logic [NUM_ENTRY-1:0] valid_q;
    tag_t                 tag_q   [NUM_ENTRY];
    value_t               value_q [NUM_ENTRY];
    conf_t                conf_q  [NUM_ENTRY];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= '0;
        end else if (wr_i.en) begin
            valid_q[wr_i.index] <= wr_i.entry.valid;
        end
    end

    // payload storage
    always_ff @(posedge clk_i) begin
        if (wr_i.en) begin
            tag_q[wr_i.index]   <= wr_i.entry.tag;
            value_q[wr_i.index] <= wr_i.entry.value;
            conf_q[wr_i.index]  <= wr_i.entry.conf;
        end
    end

    assign rd_entry_o = '{
        valid: valid_q[rd_index_i],
        tag:   tag_q[rd_index_i],
        value: value_q[rd_index_i],
        conf:  conf_q[rd_index_i]
    };

    assign fb_entry_o = '{
        valid: valid_q[fb_index_i],
        tag:   tag_q[fb_index_i],
        value: value_q[fb_index_i],
        conf:  conf_q[fb_index_i]
    };

    assign rd_hit_o = rd_entry_o.valid && (rd_entry_o.tag == rd_tag_i);

endmodule

// ==== verilog/vtage_hash.sv ====
// ************************************************************************
// index and tag hash for one bank
// folds pc and the bank's history slice, baseline uses the pc alone
// ************************************************************************
module vtage_hash (
    input  vtage_pkg::bank_t       bank_i,
    input  vtage_pkg::lookup_req_t req_i,
    output vtage_pkg::index_t      index_o,
    output vtage_pkg::tag_t        tag_o
);
    import vtage_pkg::*;

    localparam int PC_W        = $bits(pc_t);
    localparam int PC_CH_IDX   = (PC_W + INDEX_WIDTH - 1) / INDEX_WIDTH;
    localparam int PC_CH_TAG   = (PC_W + TAG_WIDTH - 1) / TAG_WIDTH;
    localparam int HIST_CH_IDX = (HIST_WIDTH + INDEX_WIDTH - 1) / INDEX_WIDTH;
    localparam int HIST_CH_TAG = (HIST_WIDTH + TAG_WIDTH - 1) / TAG_WIDTH;

    hist_t                              hist_trunc;
    logic [PC_CH_IDX*INDEX_WIDTH-1:0]   pc_pad_idx;
    logic [PC_CH_TAG*TAG_WIDTH-1:0]     pc_pad_tag;
    logic [HIST_CH_IDX*INDEX_WIDTH-1:0] hist_pad_idx;
    logic [HIST_CH_TAG*TAG_WIDTH-1:0]   hist_pad_tag;
    index_t                             idx_fold;
    tag_t                               tag_fold;

    // history length grows by 4x per bank
    always_comb begin
        case (bank_i)
            bank_t'(1): hist_trunc = req_i.hist & {{(HIST_WIDTH-4){1'b0}}, 4'hf};
            bank_t'(2): hist_trunc = req_i.hist & {{(HIST_WIDTH-16){1'b0}}, 16'hffff};
            bank_t'(3): hist_trunc = req_i.hist;
            default:    hist_trunc = '0;   // baseline, history unused
        endcase
    end

    always_comb begin
        pc_pad_idx                   = '0;   // top chunk zero padded
        pc_pad_idx[PC_W-1:0]         = req_i.pc;
        pc_pad_tag                   = '0;
        pc_pad_tag[PC_W-1:0]         = req_i.pc;
        hist_pad_idx                 = '0;
        hist_pad_idx[HIST_WIDTH-1:0] = hist_trunc;
        hist_pad_tag                 = '0;
        hist_pad_tag[HIST_WIDTH-1:0] = hist_trunc;

        idx_fold = index_t'(bank_i);
        for (int i = 0; i < PC_CH_IDX; i++) begin
            idx_fold ^= pc_pad_idx[i*INDEX_WIDTH +: INDEX_WIDTH];
        end
        for (int i = 0; i < HIST_CH_IDX; i++) begin
            idx_fold ^= hist_pad_idx[i*INDEX_WIDTH +: INDEX_WIDTH];
        end

        tag_fold = tag_t'(bank_i);
        for (int i = 0; i < PC_CH_TAG; i++) begin
            tag_fold ^= pc_pad_tag[i*TAG_WIDTH +: TAG_WIDTH];
        end
        for (int i = 0; i < HIST_CH_TAG; i++) begin
            tag_fold ^= hist_pad_tag[i*TAG_WIDTH +: TAG_WIDTH];
        end
    end

    assign index_o = (bank_i == '0) ? pc_pad_idx[INDEX_WIDTH-1:0] : idx_fold;
    assign tag_o   = (bank_i == '0) ? '0 : tag_fold;   // baseline is untagged

endmodule

// ==== verilog/vtage_pkg.sv ====
// ************************************************************************
// vtage predictor shared definitions
// widths, limits and the packed structs passed between the blocks
// ************************************************************************
package vtage_pkg;

    localparam int INDEX_WIDTH = 8;   // 256 entries per bank
    localparam int TAG_WIDTH   = 6;
    localparam int CONF_WIDTH  = 3;
    localparam int MAX_BANK    = 4;   // NUM_BANK may not exceed this
    localparam int HIST_WIDTH  = 64;

    typedef logic [31:1]                   pc_t;    // halfword aligned address
    typedef logic [HIST_WIDTH-1:0]         hist_t;
    typedef logic [31:0]                   value_t;
    typedef logic [CONF_WIDTH-1:0]         conf_t;
    typedef logic [$clog2(MAX_BANK)-1:0]   bank_t;
    typedef logic [INDEX_WIDTH-1:0]        index_t;
    typedef logic [TAG_WIDTH-1:0]          tag_t;

    localparam conf_t CONF_MAX = conf_t'((1 << CONF_WIDTH) - 1);

    typedef struct packed {
        pc_t   pc;
        hist_t hist;
    } lookup_req_t;

    typedef struct packed {
        value_t value;
        conf_t  conf;
        bank_t  bank;   // provider bank
    } pred_rsp_t;

    typedef struct packed {
        pc_t    pc;
        hist_t  hist;
        bank_t  bank;   // provider reported by the prediction
        value_t actual;
    } feedback_t;

    typedef struct packed {
        logic   valid;
        tag_t   tag;
        value_t value;
        conf_t  conf;
    } entry_t;

    typedef struct packed {
        logic   en;
        index_t index;
        entry_t entry;
    } bank_wr_t;

endpackage
